//--- Bender.yml
package:
  name: octree_searcher

sources:
  - include_dirs:
      - src
    files:
      - src/tree_pkg.sv
      - src/ctrl_pkg.sv
      - src/group_fifo_if.sv
      - src/group_fifo.sv
      - src/node_decode.sv
      - src/search_ctrl.sv
      - src/feature_fetch.sv
      - src/searcher_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/tb_searcher.sv

//--- files.f
+incdir+src
src/tree_pkg.sv
src/ctrl_pkg.sv
src/group_fifo_if.sv
src/group_fifo.sv
src/node_decode.sv
src/search_ctrl.sv
src/feature_fetch.sv
src/searcher_top.sv
tb/tb_searcher.sv

//--- src/ctrl_pkg.sv
package ctrl_pkg;

  // top phase sequencing
  typedef enum logic [1:0] {
    S_IDLE,
    S_SEARCH,
    S_FEATURES
  } search_state_e;

  // anchor queue walker
  typedef enum logic [1:0] {
    F_IDLE,
    F_POP,
    F_READ
  } fetch_state_e;

endpackage

//--- src/feature_fetch.sv
`timescale 1ns/100ps
`include "searcher_consts.svh"

module feature_fetch (
  input logic clk,
  input logic rst_n,
  input logic fetch_go,
  group_fifo_if.reader aq,
  output logic feat_rd,
  output tree_pkg::addr_t feat_addr,
  input tree_pkg::word_t mem_rdata,
  output tree_pkg::word_t feature_out,
  output logic feature_valid,
  output logic fetch_done
);

  localparam int WW = $clog2(`FEATURE_LEN);

  ctrl_pkg::fetch_state_e state;
  logic pop_q;
  tree_pkg::level_t grp_lvl;
  tree_pkg::path_t grp_path;
  tree_pkg::mask_t grp_mask;
  tree_pkg::level_t cur_lvl;
  tree_pkg::path_t cur_path;
  tree_pkg::mask_t cur_mask;
  tree_pkg::mask_t next_mask;
  logic [WW-1:0] word_cnt;
  logic last_word;
  tree_pkg::addr_t anchor_id;
  tree_pkg::addr_t word_addr;
  logic data_v;

  always_comb begin
    if (pop_q) begin
      cur_lvl = aq.rdata.level;
      cur_path = aq.rdata.path;
      cur_mask = aq.rdata.mask;
    end else begin
      cur_lvl = grp_lvl;
      cur_path = grp_path;
      cur_mask = grp_mask;
    end
  end

  assign next_mask = cur_mask & (cur_mask - 1'b1);
  assign last_word = (word_cnt == WW'(`FEATURE_LEN - 1));

  // anchors sit one level below the node that listed them
  assign anchor_id = tree_pkg::level_base(cur_lvl + 1'b1)
                   + tree_pkg::addr_t'(tree_pkg::path_t'({cur_path,
                                                          tree_pkg::first_child(cur_mask)}));
  assign word_addr = tree_pkg::addr_t'(`FEATURE_BASE) + anchor_id * `FEATURE_LEN
                   + tree_pkg::addr_t'(word_cnt);

  assign aq.pop = (state == ctrl_pkg::F_POP) && !aq.empty;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ctrl_pkg::F_IDLE;
      pop_q <= 1'b0;
      grp_mask <= '0;
      word_cnt <= '0;
      feat_rd <= 1'b0;
      data_v <= 1'b0;
      feature_valid <= 1'b0;
      fetch_done <= 1'b0;
    end else begin
      pop_q <= aq.pop;
      data_v <= feat_rd;
      feature_valid <= data_v;
      fetch_done <= 1'b0;
      feat_rd <= 1'b0;
      case (state)
        ctrl_pkg::F_IDLE: begin
          if (fetch_go) begin
            state <= ctrl_pkg::F_POP;
          end
        end
        ctrl_pkg::F_POP: begin
          if (!aq.empty) begin
            state <= ctrl_pkg::F_READ;
          end else if (!feat_rd && !data_v) begin
            // last word has left, done
            state <= ctrl_pkg::F_IDLE;
            fetch_done <= 1'b1;
          end
        end
        ctrl_pkg::F_READ: begin
          feat_rd <= 1'b1;
          if (last_word) begin
            word_cnt <= '0;
            grp_mask <= next_mask;
            if (next_mask == '0) begin
              state <= ctrl_pkg::F_POP;
            end
          end else begin
            word_cnt <= word_cnt + 1'b1;
            grp_mask <= cur_mask;
          end
        end
        default: state <= ctrl_pkg::F_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    grp_lvl <= cur_lvl;
    grp_path <= cur_path;
    if (state == ctrl_pkg::F_READ) begin
      feat_addr <= word_addr;
    end
    if (data_v) begin
      feature_out <= mem_rdata;
    end
  end

endmodule

//--- src/group_fifo.sv
`timescale 1ns/100ps
`include "searcher_consts.svh"

module group_fifo #(
  parameter int DEPTH = `GROUP_FIFO_DEPTH
) (
  input logic clk,
  input logic rst_n,
  group_fifo_if.fifo q
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  tree_pkg::node_group_t mem [DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [PW:0] count;
  logic do_push;
  logic do_pop;

  // pointers wrap at DEPTH so any depth works
  function automatic logic [PW-1:0] next_ptr(logic [PW-1:0] p);
    return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign do_push = q.push && !q.full;
  assign do_pop = q.pop && !q.empty;
  assign q.empty = (count == '0);
  assign q.full = (count == (PW+1)'(DEPTH));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({do_push, do_pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= q.wdata;
    end
    if (do_pop) begin
      q.rdata <= mem[rd_ptr];
    end
  end

  // no back-pressure upstream, so the queue must never fill
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) q.push |-> !q.full)
    else $error("group_fifo: push while full");

  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) q.pop |-> !q.empty)
    else $error("group_fifo: pop while empty");

endmodule

//--- src/group_fifo_if.sv
`timescale 1ns/100ps

interface group_fifo_if;

  logic push;
  tree_pkg::node_group_t wdata;
  logic full;

  // rdata follows pop by one cycle
  logic pop;
  tree_pkg::node_group_t rdata;
  logic empty;

  modport writer (output push, output wdata, input full);
  modport reader (output pop, input rdata, input empty);
  modport fifo (input push, input wdata, input pop, output full, output rdata, output empty);

endinterface

//--- src/node_decode.sv
`timescale 1ns/100ps
`include "searcher_consts.svh"

module node_decode (
  input logic clk,
  input logic rst_n,
  input logic node_valid,
  input tree_pkg::level_t node_level,
  input tree_pkg::path_t node_path,
  input tree_pkg::word_t mem_rdata,
  input logic [`TREE_LEVEL-1:0] lod_active,
  group_fifo_if.writer sq,
  group_fifo_if.writer aq
);

  tree_pkg::mask_t child_mask;
  tree_pkg::mask_t anchor_mask;
  tree_pkg::level_t child_lvl;
  logic [`TREE_LEVEL-1:0] lod_sel;
  logic child_keep;
  logic anchor_keep;

  // low byte nodes, next byte anchors
  assign child_mask = mem_rdata[`CHILD_NUM-1:0];
  assign anchor_mask = mem_rdata[2*`CHILD_NUM-1:`CHILD_NUM];
  assign child_lvl = node_level + 1'b1;

  // leaf level nodes are never read, so their groups are dropped here
  assign child_keep = (child_mask != '0) && (child_lvl < `TREE_LEVEL - 1);

  // shift past the top level gives zero, which drops too-deep anchors
  assign lod_sel = lod_active >> child_lvl;
  assign anchor_keep = (anchor_mask != '0) && lod_sel[0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sq.push <= 1'b0;
      aq.push <= 1'b0;
    end else begin
      sq.push <= node_valid && child_keep;
      aq.push <= node_valid && anchor_keep;
    end
  end

  // both groups carry the parent, the fetcher adds one level itself
  always_ff @(posedge clk) begin
    if (node_valid) begin
      sq.wdata <= '{level: node_level, path: node_path, mask: child_mask};
      aq.wdata <= '{level: node_level, path: node_path, mask: anchor_mask};
    end
  end

endmodule

//--- src/search_ctrl.sv
`timescale 1ns/100ps
`include "searcher_consts.svh"

module search_ctrl (
  input logic clk,
  input logic rst_n,
  input logic search_start,
  group_fifo_if.reader sq,
  output logic mem_cen,
  output tree_pkg::addr_t mem_addr,
  output logic node_valid,
  output tree_pkg::level_t node_level,
  output tree_pkg::path_t node_path,
  output logic fetch_go,
  input logic fetch_done,
  input logic feat_rd,
  input tree_pkg::addr_t feat_addr,
  output logic search_done
);

  ctrl_pkg::search_state_e state;

  // group under expansion
  logic pop_q;
  tree_pkg::level_t grp_lvl;
  tree_pkg::path_t grp_path;
  tree_pkg::mask_t grp_mask;
  tree_pkg::level_t cur_lvl;
  tree_pkg::path_t cur_path;
  tree_pkg::mask_t cur_mask;
  tree_pkg::mask_t next_mask;
  logic last_child;

  tree_pkg::level_t child_lvl;
  tree_pkg::path_t child_path;
  tree_pkg::addr_t child_addr;
  logic issue_root;
  logic issue_child;

  // stage one holds the request on the sram port
  logic req_v;
  tree_pkg::addr_t req_addr;
  tree_pkg::level_t req_lvl;
  tree_pkg::path_t req_path;

  logic idle_now;
  logic settle_q;

  // a freshly popped group is used straight from the queue
  always_comb begin
    if (pop_q) begin
      cur_lvl = sq.rdata.level;
      cur_path = sq.rdata.path;
      cur_mask = sq.rdata.mask;
    end else begin
      cur_lvl = grp_lvl;
      cur_path = grp_path;
      cur_mask = grp_mask;
    end
  end

  assign next_mask = cur_mask & (cur_mask - 1'b1);
  assign last_child = (next_mask == '0);
  assign child_lvl = cur_lvl + 1'b1;
  assign child_path = tree_pkg::path_t'({cur_path, tree_pkg::first_child(cur_mask)});
  assign child_addr = tree_pkg::addr_t'(`TREE_BASE) + tree_pkg::level_base(child_lvl)
                    + tree_pkg::addr_t'(child_path);

  assign issue_root = (state == ctrl_pkg::S_IDLE) && search_start;
  assign issue_child = (state == ctrl_pkg::S_SEARCH) && (cur_mask != '0);

  // fetch the next group while the last child of this one goes out
  assign sq.pop = (state == ctrl_pkg::S_SEARCH) && !sq.empty && last_child;

  // decode pushes one cycle after node_valid and settle_q covers that gap
  assign idle_now = sq.empty && !pop_q && (cur_mask == '0) && !req_v && !node_valid;

  always_comb begin
    if (state == ctrl_pkg::S_FEATURES) begin
      mem_cen = !feat_rd;
      mem_addr = feat_addr;
    end else begin
      mem_cen = !req_v;
      mem_addr = req_addr;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ctrl_pkg::S_IDLE;
      pop_q <= 1'b0;
      grp_mask <= '0;
      req_v <= 1'b0;
      node_valid <= 1'b0;
      settle_q <= 1'b0;
      fetch_go <= 1'b0;
      search_done <= 1'b0;
    end else begin
      pop_q <= sq.pop;
      req_v <= issue_root || issue_child;
      node_valid <= req_v;
      settle_q <= (state == ctrl_pkg::S_SEARCH) && idle_now;
      fetch_go <= 1'b0;
      search_done <= 1'b0;
      case (state)
        ctrl_pkg::S_IDLE: begin
          if (search_start) begin
            state <= ctrl_pkg::S_SEARCH;
          end
        end
        ctrl_pkg::S_SEARCH: begin
          grp_mask <= next_mask;
          if (idle_now && settle_q) begin
            state <= ctrl_pkg::S_FEATURES;
            fetch_go <= 1'b1;
          end
        end
        ctrl_pkg::S_FEATURES: begin
          if (fetch_done) begin
            state <= ctrl_pkg::S_IDLE;
            search_done <= 1'b1;
          end
        end
        default: state <= ctrl_pkg::S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    grp_lvl <= cur_lvl;
    grp_path <= cur_path;
    if (issue_root) begin
      req_addr <= tree_pkg::addr_t'(`TREE_BASE) + tree_pkg::level_base('0);
      req_lvl <= '0;
      req_path <= '0;
    end else if (issue_child) begin
      req_addr <= child_addr;
      req_lvl <= child_lvl;
      req_path <= child_path;
    end
    // stage two matches the word now on mem_rdata
    node_level <= req_lvl;
    node_path <= req_path;
  end

  // node words only come back while the tree is walked
  a_node_in_search: assert property (@(posedge clk) disable iff (!rst_n)
    node_valid |-> state == ctrl_pkg::S_SEARCH)
    else $error("search_ctrl: node_valid outside search phase");

  // every queued group names at least one child to read
  a_sq_group: assert property (@(posedge clk) disable iff (!rst_n)
    pop_q |-> sq.rdata.mask != '0)
    else $error("search_ctrl: popped group has no children");

endmodule

//--- src/searcher_consts.svh
`ifndef SEARCHER_CONSTS_SVH
`define SEARCHER_CONSTS_SVH

// tree shape
`define TREE_LEVEL 5
`define LOG_CHILD 3
`define CHILD_NUM 8

// feature words per anchor
`define FEATURE_LEN 9

// sram port
`define ADDR_W 16
`define DATA_W 64

// region bases in the sram
`define TREE_BASE 0
`define FEATURE_BASE 1200

// entries per group queue
`define GROUP_FIFO_DEPTH 32

`endif

//--- src/searcher_top.sv
`timescale 1ns/100ps
`include "searcher_consts.svh"

module searcher_top (
  input logic clk,
  input logic rst_n,
  input logic search_start,
  input logic [`TREE_LEVEL-1:0] lod_active,
  output logic mem_cen,
  output tree_pkg::addr_t mem_addr,
  input tree_pkg::word_t mem_rdata,
  output tree_pkg::word_t feature_out,
  output logic feature_valid,
  output logic search_done
);

  logic node_valid;
  tree_pkg::level_t node_level;
  tree_pkg::path_t node_path;
  logic fetch_go;
  logic fetch_done;
  logic feat_rd;
  tree_pkg::addr_t feat_addr;

  // nodes still to expand, and anchors waiting for features
  group_fifo_if search_q ();
  group_fifo_if anchor_q ();

  group_fifo #(
    .DEPTH(`GROUP_FIFO_DEPTH)
  ) u_search_fifo (
    .clk  (clk),
    .rst_n(rst_n),
    .q    (search_q)
  );

  group_fifo #(
    .DEPTH(`GROUP_FIFO_DEPTH)
  ) u_anchor_fifo (
    .clk  (clk),
    .rst_n(rst_n),
    .q    (anchor_q)
  );

  search_ctrl u_search_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .search_start(search_start),
    .sq          (search_q),
    .mem_cen     (mem_cen),
    .mem_addr    (mem_addr),
    .node_valid  (node_valid),
    .node_level  (node_level),
    .node_path   (node_path),
    .fetch_go    (fetch_go),
    .fetch_done  (fetch_done),
    .feat_rd     (feat_rd),
    .feat_addr   (feat_addr),
    .search_done (search_done)
  );

  node_decode u_node_decode (
    .clk       (clk),
    .rst_n     (rst_n),
    .node_valid(node_valid),
    .node_level(node_level),
    .node_path (node_path),
    .mem_rdata (mem_rdata),
    .lod_active(lod_active),
    .sq        (search_q),
    .aq        (anchor_q)
  );

  feature_fetch u_feature_fetch (
    .clk          (clk),
    .rst_n        (rst_n),
    .fetch_go     (fetch_go),
    .aq           (anchor_q),
    .feat_rd      (feat_rd),
    .feat_addr    (feat_addr),
    .mem_rdata    (mem_rdata),
    .feature_out  (feature_out),
    .feature_valid(feature_valid),
    .fetch_done   (fetch_done)
  );

endmodule

//--- src/tree_pkg.sv
`include "searcher_consts.svh"

package tree_pkg;

  typedef logic [2:0] level_t;
  // one octal digit per level below the root
  typedef logic [`LOG_CHILD*`TREE_LEVEL-1:0] path_t;
  typedef logic [`CHILD_NUM-1:0] mask_t;
  typedef logic [`ADDR_W-1:0] addr_t;
  typedef logic [`DATA_W-1:0] word_t;

  // parent node plus the children still to visit
  typedef struct packed {
    level_t level;
    path_t path;
    mask_t mask;
  } node_group_t;

  // offset of the first node of a level, sum of 8^k below it
  function automatic addr_t level_base(level_t lvl);
    addr_t base;
    addr_t span;
    base = '0;
    span = addr_t'(1);
    for (int l = 0; l < `TREE_LEVEL; l++) begin
      if (l < int'(lvl)) begin
        base = base + span;
      end
      span = span << `LOG_CHILD;
    end
    return base;
  endfunction

  // index of the lowest set child bit, zero for an empty mask
  function automatic logic [`LOG_CHILD-1:0] first_child(mask_t m);
    logic [`LOG_CHILD-1:0] idx;
    idx = '0;
    for (int i = `CHILD_NUM - 1; i >= 0; i--) begin
      if (m[i]) begin
        idx = (`LOG_CHILD)'(i);
      end
    end
    return idx;
  endfunction

endpackage

//--- tb/tb_searcher.sv
`timescale 1ns/100ps
`include "searcher_consts.svh"

module tb_searcher;

  // nine runs of at most 2200 cycles each and the reset
  localparam int RUN_COUNT = 9;
  localparam int RUN_LIMIT = 2200;
  localparam int TIMEOUT_CYCLES = RUN_COUNT * RUN_LIMIT + 200;
  localparam int MEM_WORDS = 1 << `ADDR_W;
  localparam int MAX_NODES = 24;

  logic clk;
  logic rst_n;
  logic search_start;
  logic [`TREE_LEVEL-1:0] lod_active;
  logic mem_cen;
  tree_pkg::addr_t mem_addr;
  tree_pkg::word_t mem_rdata;
  tree_pkg::word_t feature_out;
  logic feature_valid;
  logic search_done;

  tree_pkg::word_t sram [MEM_WORDS];
  tree_pkg::word_t exp_q[$];
  logic [31:0] lfsr;
  int errors;
  int checks;
  int wd_cycles;

  searcher_top u_searcher_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .search_start (search_start),
    .lod_active   (lod_active),
    .mem_cen      (mem_cen),
    .mem_addr     (mem_addr),
    .mem_rdata    (mem_rdata),
    .feature_out  (feature_out),
    .feature_valid(feature_valid),
    .search_done  (search_done)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // single port sram returns data one cycle after the read
  always @(posedge clk) begin
    if (mem_cen === 1'b0) begin
      if ($isunknown(mem_addr)) begin
        errors++;
        $display("sram read with an unknown address at %0t", $time);
      end else begin
        mem_rdata <= sram[mem_addr];
      end
    end
  end

  initial begin
    wd_cycles = 0;
    while (wd_cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      wd_cycles++;
    end
    $display("timeout: run still going after %0d cycles", wd_cycles);
    $display("Finished with errors");
    $finish;
  end

  // 32 bit galois lfsr
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // sparse masks take two bits per child
  task automatic random_mask(input bit sparse, output tree_pkg::mask_t m);
    for (int i = 0; i < `CHILD_NUM; i++) begin
      lfsr = lfsr_next(lfsr);
      m[i] = lfsr[0];
      if (sparse) begin
        lfsr = lfsr_next(lfsr);
        m[i] = m[i] & lfsr[0];
      end
    end
  endtask

  // first index of a level is (8^l - 1) / 7
  function automatic int node_base(int lvl);
    return ((1 << (`LOG_CHILD * lvl)) - 1) / (`CHILD_NUM - 1);
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t %s got %0h exp %0h", $time, name, got, exp);
    end
  endtask

  task automatic fill_memory();
    for (int a = 0; a < MEM_WORDS; a++) begin
      sram[a] = (a >= `FEATURE_BASE) ? tree_pkg::word_t'(a) : '0;
    end
  endtask

  task automatic clear_tree();
    for (int a = 0; a < `FEATURE_BASE; a++) begin
      sram[a] = '0;
    end
  endtask

  // upper bits hold junk the decoder must ignore
  task automatic set_node(input int lvl, input int path, input tree_pkg::mask_t cm,
                          input tree_pkg::mask_t am);
    sram[`TREE_BASE + node_base(lvl) + path] = {48'h5a5a_c3c3_0f0f, am, cm};
  endtask

  // breadth first walk over the sram model
  task automatic build_expected(input logic [`TREE_LEVEL-1:0] lod);
    int q_lvl[$];
    int q_path[$];
    int lvl;
    int path;
    int id;
    tree_pkg::word_t w;
    exp_q.delete();
    q_lvl.push_back(0);
    q_path.push_back(0);
    while (q_lvl.size() > 0) begin
      lvl = q_lvl.pop_front();
      path = q_path.pop_front();
      w = sram[`TREE_BASE + node_base(lvl) + path];
      for (int i = 0; i < `CHILD_NUM; i++) begin
        if (w[`CHILD_NUM + i] && (lvl + 1 < `TREE_LEVEL) && lod[lvl + 1]) begin
          id = node_base(lvl + 1) + path * `CHILD_NUM + i;
          for (int k = 0; k < `FEATURE_LEN; k++) begin
            exp_q.push_back(tree_pkg::word_t'(`FEATURE_BASE + id * `FEATURE_LEN + k));
          end
        end
      end
      for (int i = 0; i < `CHILD_NUM; i++) begin
        if (w[i] && (lvl + 1 < `TREE_LEVEL - 1)) begin
          q_lvl.push_back(lvl + 1);
          q_path.push_back(path * `CHILD_NUM + i);
        end
      end
    end
  endtask

  // start once and compare the stream up to search_done with the model
  task automatic run_search(input logic [`TREE_LEVEL-1:0] lod, input bit poke);
    tree_pkg::word_t got[$];
    int cyc;
    int last_fv;
    int n;
    bit done;
    build_expected(lod);
    @(posedge clk);
    lod_active <= lod;
    search_start <= 1'b1;
    cyc = 0;
    last_fv = -1;
    done = 1'b0;
    while (!done) begin
      @(posedge clk);
      // extra starts land inside the run
      search_start <= poke && (cyc == 3 || cyc == exp_q.size());
      @(negedge clk);
      if (feature_valid) begin
        got.push_back(feature_out);
        last_fv = cyc;
      end
      if (search_done) begin
        done = 1'b1;
        if (last_fv == cyc) begin
          errors++;
          $display("search_done came in the same cycle as a feature word at %0t", $time);
        end
      end
      cyc++;
    end
    repeat (2) begin
      @(negedge clk);
      check("feature_valid", feature_valid, 1'b0);
      check("search_done", search_done, 1'b0);
      check("mem_cen", mem_cen, 1'b1);
    end
    check("feature count", got.size(), exp_q.size());
    n = (got.size() < exp_q.size()) ? got.size() : exp_q.size();
    for (int i = 0; i < n; i++) begin
      check("feature_out", got[i], exp_q[i]);
    end
  endtask

  // root with three level-1 children and anchors on both levels
  task automatic build_two_level();
    clear_tree();
    set_node(0, 0, 8'b0100_0110, 8'b1000_0001);
    set_node(1, 1, 8'h00, 8'b0000_0011);
    set_node(1, 2, 8'h00, 8'b0110_0000);
    set_node(1, 6, 8'h00, 8'b1000_0000);
  endtask

  task automatic build_random_tree();
    tree_pkg::mask_t root_c;
    tree_pkg::mask_t root_a;
    tree_pkg::mask_t c1;
    tree_pkg::mask_t a1;
    tree_pkg::mask_t a2;
    int nodes;
    clear_tree();
    random_mask(1'b0, root_c);
    random_mask(1'b0, root_a);
    set_node(0, 0, root_c, root_a);
    nodes = 1;
    for (int i = 0; i < `CHILD_NUM; i++) begin
      if (root_c[i]) begin
        random_mask(1'b1, c1);
        random_mask(1'b0, a1);
        set_node(1, i, c1, a1);
        nodes++;
        // cap keeps the anchor queue well inside its depth
        for (int j = 0; j < `CHILD_NUM; j++) begin
          if (c1[j] && nodes < MAX_NODES) begin
            random_mask(1'b0, a2);
            set_node(2, i * `CHILD_NUM + j, 8'h00, a2);
            nodes++;
          end
        end
      end
    end
  endtask

  task automatic reset_and_empty_root();
    @(negedge clk);
    check("mem_cen", mem_cen, 1'b1);
    check("feature_valid", feature_valid, 1'b0);
    check("search_done", search_done, 1'b0);
    clear_tree();
    set_node(0, 0, 8'h00, 8'h00);
    run_search(5'b11111, 1'b0);
  endtask

  task automatic root_anchor_order();
    clear_tree();
    set_node(0, 0, 8'h00, 8'b1010_0101);
    run_search(5'b11111, 1'b0);
  endtask

  task automatic lod_level_masking();
    build_two_level();
    run_search(5'b11111, 1'b0);
    run_search(5'b11101, 1'b0);
    run_search(5'b11011, 1'b0);
    run_search(5'b11001, 1'b0);
  endtask

  task automatic random_tree_match();
    build_random_tree();
    run_search(5'b11111, 1'b0);
  endtask

  task automatic restart_during_run();
    build_two_level();
    run_search(5'b11111, 1'b1);
    run_search(5'b11111, 1'b0);
  endtask

  initial begin
    errors = 0;
    checks = 0;
    lfsr = 32'h5653;
    rst_n = 1'b0;
    search_start = 1'b0;
    lod_active = '0;
    mem_rdata = '0;
    fill_memory();
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    reset_and_empty_root();
    root_anchor_order();
    lod_level_masking();
    random_tree_match();
    restart_during_run();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
